//--- hw/lq_pkg.sv
`default_nettype none

package lq_pkg;

    localparam int XLEN = 64;
    localparam int DATA_BYTES = XLEN / 8;
    localparam int ROB_IDX_W = 6;
    localparam int REG_IDX_W = 7;

    typedef logic [XLEN-1:0] xdata_t;
    typedef logic [DATA_BYTES-1:0] byte_mask_t;
    typedef logic [ROB_IDX_W-1:0] rob_idx_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    // what the register file and rob need on writeback
    typedef struct packed {
        reg_idx_t rd;
        rob_idx_t rob_idx;
        logic we;
    } lq_tag_t;

endpackage

`default_nettype wire

//--- hw/lq_ram.sv
`timescale 1ns/100ps
`default_nettype none

module lq_ram #(
    parameter type T = logic,
    parameter int LQ_DEPTH = 16,
    localparam int IDX_W = $clog2(LQ_DEPTH)
) (
    input  wire logic             clk,
    input  wire logic             we_i,
    input  wire logic [IDX_W-1:0] waddr_i,
    input  wire T                 wdata_i,
    input  wire logic [IDX_W-1:0] raddr_i,
    output T                      rdata_o
);

    T mem [LQ_DEPTH];

    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[waddr_i] <= wdata_i;
        end
    end

    // read is asynchronous, the selector registers it
    assign rdata_o = mem[raddr_i];

endmodule

`default_nettype wire

//--- hw/lq_pointer_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module lq_pointer_ctrl #(
    parameter int LQ_DEPTH = 16,
    parameter int COMMIT_WIDTH = 2,
    localparam int IDX_W = $clog2(LQ_DEPTH),
    localparam int CNT_W = $clog2(COMMIT_WIDTH + 1)
) (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                dis_en_i,
    input  wire logic [CNT_W-1:0]    commit_num_i,
    output logic      [IDX_W-1:0]    dis_lq_idx_o,
    output logic                     dis_lq_dir_o,
    output logic                     full_o,
    output logic                     alloc_en_o,
    output logic      [IDX_W-1:0]    alloc_idx_o,
    output logic      [LQ_DEPTH-1:0] free_mask_o
);

    localparam int PTR_W = IDX_W + 1;

    // msb of each pointer is the wrap bit
    logic [PTR_W-1:0] head_q;
    logic [PTR_W-1:0] tail_q;

    assign full_o = (head_q[IDX_W-1:0] == tail_q[IDX_W-1:0]) &&
                    (head_q[IDX_W] != tail_q[IDX_W]);

    assign dis_lq_idx_o = tail_q[IDX_W-1:0];
    assign dis_lq_dir_o = tail_q[IDX_W];
    assign alloc_en_o = dis_en_i & ~full_o;
    assign alloc_idx_o = tail_q[IDX_W-1:0];

    // slots retired from the head this cycle
    always_comb begin : free_gen
        logic [IDX_W-1:0] slot;
        free_mask_o = '0;
        for (int i = 0; i < COMMIT_WIDTH; i++) begin
            slot = head_q[IDX_W-1:0] + IDX_W'(i);
            if (i < int'(commit_num_i)) begin
                free_mask_o[slot] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            head_q <= '0;
            tail_q <= '0;
        end else begin
            head_q <= head_q + PTR_W'(commit_num_i);
            tail_q <= tail_q + PTR_W'(alloc_en_o);
        end
    end

endmodule

`default_nettype wire

//--- hw/lq_entry_state.sv
`timescale 1ns/100ps
`default_nettype none

module lq_entry_state import lq_pkg::*; #(
    parameter int LQ_DEPTH = 16,
    localparam int IDX_W = $clog2(LQ_DEPTH)
) (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                alloc_en_i,
    input  wire logic [IDX_W-1:0]    alloc_idx_i,
    input  wire rob_idx_t            alloc_rob_idx_i,
    input  wire logic [LQ_DEPTH-1:0] free_mask_i,
    input  wire logic                iss_en_i,
    input  wire logic [IDX_W-1:0]    iss_lq_idx_i,
    input  wire reg_idx_t            iss_rd_i,
    input  wire logic                iss_we_i,
    input  wire logic                iss_miss_i,
    input  wire byte_mask_t          iss_fwd_mask_i,
    input  wire xdata_t              iss_fwd_data_i,
    input  wire logic                refill_en_i,
    input  wire logic [IDX_W-1:0]    refill_lq_idx_i,
    input  wire xdata_t              refill_data_i,
    input  wire logic                wb_done_i,
    input  wire logic [IDX_W-1:0]    wb_done_idx_i,
    input  wire logic [IDX_W-1:0]    rd_idx_i,
    output logic      [LQ_DEPTH-1:0] pending_o,
    output lq_tag_t                  rd_tag_o,
    output xdata_t                   rd_data_o
);

    logic [LQ_DEPTH-1:0] valid_q;
    logic [LQ_DEPTH-1:0] miss_q;
    logic [LQ_DEPTH-1:0] dvalid_q;
    logic [LQ_DEPTH-1:0] wbd_q;

    rob_idx_t   rob_idx_q [LQ_DEPTH];
    byte_mask_t fwd_mask_q [LQ_DEPTH];
    xdata_t     fwd_data_q [LQ_DEPTH];

    lq_tag_t iss_tag;
    xdata_t  refill_merged;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid_q <= '0;
            miss_q <= '0;
            dvalid_q <= '0;
            wbd_q <= '0;
        end else begin
            valid_q <= valid_q & ~free_mask_i;
            if (alloc_en_i) begin
                valid_q[alloc_idx_i] <= 1'b1;
                miss_q[alloc_idx_i] <= 1'b0;
                dvalid_q[alloc_idx_i] <= 1'b0;
                wbd_q[alloc_idx_i] <= 1'b0;
            end
            // hits are complete at issue and never wait for writeback
            if (iss_en_i) begin
                miss_q[iss_lq_idx_i] <= iss_miss_i;
                dvalid_q[iss_lq_idx_i] <= ~iss_miss_i;
                wbd_q[iss_lq_idx_i] <= ~iss_miss_i;
            end
            if (refill_en_i) begin
                dvalid_q[refill_lq_idx_i] <= 1'b1;
            end
            if (wb_done_i) begin
                wbd_q[wb_done_idx_i] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_en_i) begin
            rob_idx_q[alloc_idx_i] <= alloc_rob_idx_i;
        end
        // a hit keeps every byte as forwarded
        if (iss_en_i) begin
            fwd_mask_q[iss_lq_idx_i] <= iss_miss_i ? iss_fwd_mask_i : '1;
            fwd_data_q[iss_lq_idx_i] <= iss_fwd_data_i;
        end
    end

    assign pending_o = valid_q & miss_q & dvalid_q & ~wbd_q;

    always_comb begin
        iss_tag.rd = iss_rd_i;
        iss_tag.rob_idx = rob_idx_q[iss_lq_idx_i];
        iss_tag.we = iss_we_i;
    end

    // forwarded bytes win over refill bytes
    always_comb begin
        for (int b = 0; b < DATA_BYTES; b++) begin
            refill_merged[b*8 +: 8] = fwd_mask_q[refill_lq_idx_i][b] ?
                                      fwd_data_q[refill_lq_idx_i][b*8 +: 8] :
                                      refill_data_i[b*8 +: 8];
        end
    end

    lq_ram #(
        .T        (lq_tag_t),
        .LQ_DEPTH (LQ_DEPTH)
    ) u_tag_ram (
        .clk     (clk),
        .we_i    (iss_en_i),
        .waddr_i (iss_lq_idx_i),
        .wdata_i (iss_tag),
        .raddr_i (rd_idx_i),
        .rdata_o (rd_tag_o)
    );

    lq_ram #(
        .T        (xdata_t),
        .LQ_DEPTH (LQ_DEPTH)
    ) u_data_ram (
        .clk     (clk),
        .we_i    (refill_en_i),
        .waddr_i (refill_lq_idx_i),
        .wdata_i (refill_merged),
        .raddr_i (rd_idx_i),
        .rdata_o (rd_data_o)
    );

endmodule

`default_nettype wire

//--- hw/lq_writeback.sv
`timescale 1ns/100ps
`default_nettype none

module lq_writeback import lq_pkg::*; #(
    parameter int LQ_DEPTH = 16,
    localparam int IDX_W = $clog2(LQ_DEPTH)
) (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic [LQ_DEPTH-1:0] pending_i,
    input  wire lq_tag_t             rd_tag_i,
    input  wire xdata_t              rd_data_i,
    input  wire logic                wb_ready_i,
    output logic      [IDX_W-1:0]    rd_idx_o,
    output logic                     wb_done_o,
    output logic      [IDX_W-1:0]    wb_done_idx_o,
    output logic                     wb_valid_o,
    output reg_idx_t                 wb_rd_o,
    output rob_idx_t                 wb_rob_idx_o,
    output xdata_t                   wb_data_o
);

    logic                wb_valid_q;
    logic [IDX_W-1:0]    wb_idx_q;
    lq_tag_t             tag_q;
    xdata_t              data_q;

    logic [LQ_DEPTH-1:0] cand;
    logic [IDX_W-1:0]    sel_idx;
    logic                sel_found;
    logic                load_en;

    assign wb_done_o = wb_valid_q & wb_ready_i;
    assign wb_done_idx_o = wb_idx_q;

    // slot leaving this cycle still reads as pending until the edge
    always_comb begin
        cand = pending_i;
        if (wb_done_o) begin
            cand[wb_idx_q] = 1'b0;
        end
    end

    // lowest slot first
    always_comb begin
        sel_idx = '0;
        sel_found = 1'b0;
        for (int i = LQ_DEPTH - 1; i >= 0; i--) begin
            if (cand[i]) begin
                sel_idx = IDX_W'(i);
                sel_found = 1'b1;
            end
        end
    end

    assign rd_idx_o = sel_idx;
    assign load_en = ~wb_valid_q | wb_ready_i;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            wb_valid_q <= 1'b0;
        end else if (load_en) begin
            wb_valid_q <= sel_found;
        end
    end

    always_ff @(posedge clk) begin
        if (load_en && sel_found) begin
            wb_idx_q <= sel_idx;
            tag_q <= rd_tag_i;
            data_q <= rd_data_i;
        end
    end

    assign wb_valid_o = wb_valid_q;
    // no register write, so target p0
    assign wb_rd_o = tag_q.we ? tag_q.rd : '0;
    assign wb_rob_idx_o = tag_q.rob_idx;
    assign wb_data_o = data_q;

endmodule

`default_nettype wire

//--- hw/load_queue.sv
`timescale 1ns/100ps
`default_nettype none

module load_queue import lq_pkg::*; #(
    parameter int LQ_DEPTH = 16,
    parameter int COMMIT_WIDTH = 2,
    localparam int IDX_W = $clog2(LQ_DEPTH),
    localparam int CNT_W = $clog2(COMMIT_WIDTH + 1)
) (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic             dis_en_i,
    input  wire rob_idx_t         dis_rob_idx_i,
    output logic      [IDX_W-1:0] dis_lq_idx_o,
    output logic                  dis_lq_dir_o,
    output logic                  full_o,
    input  wire logic             iss_en_i,
    input  wire logic [IDX_W-1:0] iss_lq_idx_i,
    input  wire reg_idx_t         iss_rd_i,
    input  wire logic             iss_we_i,
    input  wire logic             iss_miss_i,
    input  wire byte_mask_t       iss_fwd_mask_i,
    input  wire xdata_t           iss_fwd_data_i,
    input  wire logic             refill_en_i,
    input  wire logic [IDX_W-1:0] refill_lq_idx_i,
    input  wire xdata_t           refill_data_i,
    output logic                  wb_valid_o,
    output reg_idx_t              wb_rd_o,
    output rob_idx_t              wb_rob_idx_o,
    output xdata_t                wb_data_o,
    input  wire logic             wb_ready_i,
    input  wire logic [CNT_W-1:0] commit_num_i
);

    logic                alloc_en;
    logic [IDX_W-1:0]    alloc_idx;
    logic [LQ_DEPTH-1:0] free_mask;
    logic [LQ_DEPTH-1:0] pending;
    logic [IDX_W-1:0]    rd_idx;
    lq_tag_t             rd_tag;
    xdata_t              rd_data;
    logic                wb_done;
    logic [IDX_W-1:0]    wb_done_idx;

    lq_pointer_ctrl #(
        .LQ_DEPTH     (LQ_DEPTH),
        .COMMIT_WIDTH (COMMIT_WIDTH)
    ) u_ptr (
        .clk          (clk),
        .rst          (rst),
        .dis_en_i     (dis_en_i),
        .commit_num_i (commit_num_i),
        .dis_lq_idx_o (dis_lq_idx_o),
        .dis_lq_dir_o (dis_lq_dir_o),
        .full_o       (full_o),
        .alloc_en_o   (alloc_en),
        .alloc_idx_o  (alloc_idx),
        .free_mask_o  (free_mask)
    );

    lq_entry_state #(
        .LQ_DEPTH (LQ_DEPTH)
    ) u_state (
        .clk             (clk),
        .rst             (rst),
        .alloc_en_i      (alloc_en),
        .alloc_idx_i     (alloc_idx),
        .alloc_rob_idx_i (dis_rob_idx_i),
        .free_mask_i     (free_mask),
        .iss_en_i        (iss_en_i),
        .iss_lq_idx_i    (iss_lq_idx_i),
        .iss_rd_i        (iss_rd_i),
        .iss_we_i        (iss_we_i),
        .iss_miss_i      (iss_miss_i),
        .iss_fwd_mask_i  (iss_fwd_mask_i),
        .iss_fwd_data_i  (iss_fwd_data_i),
        .refill_en_i     (refill_en_i),
        .refill_lq_idx_i (refill_lq_idx_i),
        .refill_data_i   (refill_data_i),
        .wb_done_i       (wb_done),
        .wb_done_idx_i   (wb_done_idx),
        .rd_idx_i        (rd_idx),
        .pending_o       (pending),
        .rd_tag_o        (rd_tag),
        .rd_data_o       (rd_data)
    );

    lq_writeback #(
        .LQ_DEPTH (LQ_DEPTH)
    ) u_wb (
        .clk           (clk),
        .rst           (rst),
        .pending_i     (pending),
        .rd_tag_i      (rd_tag),
        .rd_data_i     (rd_data),
        .wb_ready_i    (wb_ready_i),
        .rd_idx_o      (rd_idx),
        .wb_done_o     (wb_done),
        .wb_done_idx_o (wb_done_idx),
        .wb_valid_o    (wb_valid_o),
        .wb_rd_o       (wb_rd_o),
        .wb_rob_idx_o  (wb_rob_idx_o),
        .wb_data_o     (wb_data_o)
    );

endmodule

`default_nettype wire

//--- dv/lq_clk_gen.sv
`timescale 1ns/100ps
`default_nettype none

module lq_clk_gen #(
    parameter int PERIOD = 8,
    parameter int RST_CYCLES = 5
) (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

    // release just after an edge so it never races the flops
    initial begin
        rst_o = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        #1;
        rst_o = 1'b1;
    end

endmodule

`default_nettype wire

//--- dv/load_queue_properties.sv
`timescale 1ns/100ps
`default_nettype none

module load_queue_properties import lq_pkg::*; (
    input wire logic     clk,
    input wire logic     rst,
    input wire logic     dis_en_i,
    input wire logic     full_i,
    input wire logic     wb_valid_i,
    input wire logic     wb_ready_i,
    input wire reg_idx_t wb_rd_i,
    input wire rob_idx_t wb_rob_idx_i,
    input wire xdata_t   wb_data_i
);

    // read by the testbench at the end of the run
    int fail_count = 0;

    no_dispatch_when_full: assert property (
        @(posedge clk) disable iff (!rst) dis_en_i |-> !full_i
    ) else begin
        fail_count++;
        $error("dispatch raised while the queue is full");
    end

    wb_held_stable: assert property (
        @(posedge clk) disable iff (!rst)
        (wb_valid_i && !wb_ready_i) |=>
            (wb_valid_i && $stable(wb_rd_i) && $stable(wb_rob_idx_i) && $stable(wb_data_i))
    ) else begin
        fail_count++;
        $error("writeback changed while stalled by the register file");
    end

    wb_idle_in_reset: assert property (
        @(posedge clk) !rst |-> !wb_valid_i
    ) else begin
        fail_count++;
        $error("writeback valid during reset");
    end

endmodule

`default_nettype wire

//--- dv/tb_load_queue.sv
`timescale 1ns/100ps
`default_nettype none

module tb_load_queue import lq_pkg::*; ();

    localparam int LQ_DEPTH = 16;
    localparam int COMMIT_WIDTH = 2;
    localparam int IDX_W = $clog2(LQ_DEPTH);
    localparam int CNT_W = $clog2(COMMIT_WIDTH + 1);
    localparam int CLK_PERIOD = 8;
    localparam int NROWS = 37;

    typedef enum {OP_DISP, OP_COMMIT, OP_HIT, OP_MISS, OP_REFILL, OP_READY, OP_WAIT} op_e;

    // cnt is loads, entries or ready mode (0 low, 1 high, 2 random)
    typedef struct {
        op_e        op;
        int         cnt;
        int         slot;
        byte_mask_t mask;
        logic       exp_full;
        string      name;
    } row_t;

    row_t rows [NROWS] = '{
        '{OP_DISP,   16, 0, 8'h00, 1'b1, "fill_queue"},
        '{OP_COMMIT,  1, 0, 8'h00, 1'b0, "free_one"},
        '{OP_DISP,    1, 0, 8'h00, 1'b1, "wrap_dispatch"},
        '{OP_HIT,     0, 1, 8'h00, 1'b0, "hit_no_wb"},
        '{OP_MISS,    0, 2, 8'h0f, 1'b0, "miss_low_fwd"},
        '{OP_REFILL,  0, 2, 8'h00, 1'b0, "refill_single"},
        '{OP_WAIT,    0, 0, 8'h00, 1'b0, "single_wb"},
        '{OP_MISS,    0, 3, 8'h00, 1'b0, "miss_no_fwd"},
        '{OP_MISS,    0, 4, 8'hff, 1'b0, "miss_all_fwd"},
        '{OP_MISS,    0, 5, 8'ha5, 1'b0, "miss_mix_fwd"},
        '{OP_MISS,    0, 6, 8'h3c, 1'b0, "miss_mid_fwd"},
        '{OP_READY,   0, 0, 8'h00, 1'b0, "stall_port"},
        '{OP_REFILL,  0, 6, 8'h00, 1'b0, "refill_6"},
        '{OP_REFILL,  0, 4, 8'h00, 1'b0, "refill_4"},
        '{OP_REFILL,  0, 5, 8'h00, 1'b0, "refill_5"},
        '{OP_REFILL,  0, 3, 8'h00, 1'b0, "refill_3"},
        '{OP_READY,   1, 0, 8'h00, 1'b0, "release_port"},
        '{OP_WAIT,    0, 0, 8'h00, 1'b0, "ordered_drain"},
        '{OP_COMMIT,  2, 0, 8'h00, 1'b0, "commit_two_a"},
        '{OP_COMMIT,  1, 0, 8'h00, 1'b0, "commit_one_a"},
        '{OP_COMMIT,  2, 0, 8'h00, 1'b0, "commit_two_b"},
        '{OP_COMMIT,  1, 0, 8'h00, 1'b0, "commit_one_b"},
        '{OP_DISP,    6, 0, 8'h00, 1'b1, "second_lap"},
        '{OP_READY,   2, 0, 8'h00, 1'b0, "random_ready"},
        '{OP_MISS,    0, 1, 8'h81, 1'b0, "miss_edge_fwd"},
        '{OP_MISS,    0, 2, 8'h00, 1'b0, "miss_plain"},
        '{OP_MISS,    0, 3, 8'h7e, 1'b0, "miss_inner_fwd"},
        '{OP_REFILL,  0, 3, 8'h00, 1'b0, "refill_3b"},
        '{OP_REFILL,  0, 1, 8'h00, 1'b0, "refill_1b"},
        '{OP_MISS,    0, 4, 8'h0f, 1'b0, "miss_late"},
        '{OP_REFILL,  0, 2, 8'h00, 1'b0, "refill_2b"},
        '{OP_REFILL,  0, 4, 8'h00, 1'b0, "refill_4b"},
        '{OP_WAIT,    0, 0, 8'h00, 1'b0, "random_drain"},
        '{OP_READY,   1, 0, 8'h00, 1'b0, "ready_high"},
        '{OP_COMMIT,  2, 0, 8'h00, 1'b0, "commit_past_wrap"},
        '{OP_DISP,    2, 0, 8'h00, 1'b1, "refill_ring"},
        '{OP_COMMIT,  2, 0, 8'h00, 1'b0, "final_commit"}
    };

    logic             clk;
    logic             rst;
    logic             dis_en_i;
    rob_idx_t         dis_rob_idx_i;
    logic [IDX_W-1:0] dis_lq_idx_o;
    logic             dis_lq_dir_o;
    logic             full_o;
    logic             iss_en_i;
    logic [IDX_W-1:0] iss_lq_idx_i;
    reg_idx_t         iss_rd_i;
    logic             iss_we_i;
    logic             iss_miss_i;
    byte_mask_t       iss_fwd_mask_i;
    xdata_t           iss_fwd_data_i;
    logic             refill_en_i;
    logic [IDX_W-1:0] refill_lq_idx_i;
    xdata_t           refill_data_i;
    logic             wb_valid_o;
    reg_idx_t         wb_rd_o;
    rob_idx_t         wb_rob_idx_o;
    xdata_t           wb_data_o;
    logic             wb_ready_i;
    logic [CNT_W-1:0] commit_num_i;

    // reference model
    reg_idx_t            m_rd   [LQ_DEPTH];
    rob_idx_t            m_rob  [LQ_DEPTH];
    byte_mask_t          m_mask [LQ_DEPTH];
    xdata_t              m_fwd  [LQ_DEPTH];
    xdata_t              m_data [LQ_DEPTH];
    logic [LQ_DEPTH-1:0] m_pend;
    int                  held_slot;
    int                  tail_ptr;
    int                  ready_mode;
    int                  stretch;
    logic                ready_level;
    int                  errors;
    int                  checks;
    string               cur_name;

    lq_clk_gen #(
        .PERIOD     (CLK_PERIOD),
        .RST_CYCLES (5)
    ) u_clk (
        .clk_o (clk),
        .rst_o (rst)
    );

    load_queue #(
        .LQ_DEPTH     (LQ_DEPTH),
        .COMMIT_WIDTH (COMMIT_WIDTH)
    ) uut (
        .clk             (clk),
        .rst             (rst),
        .dis_en_i        (dis_en_i),
        .dis_rob_idx_i   (dis_rob_idx_i),
        .dis_lq_idx_o    (dis_lq_idx_o),
        .dis_lq_dir_o    (dis_lq_dir_o),
        .full_o          (full_o),
        .iss_en_i        (iss_en_i),
        .iss_lq_idx_i    (iss_lq_idx_i),
        .iss_rd_i        (iss_rd_i),
        .iss_we_i        (iss_we_i),
        .iss_miss_i      (iss_miss_i),
        .iss_fwd_mask_i  (iss_fwd_mask_i),
        .iss_fwd_data_i  (iss_fwd_data_i),
        .refill_en_i     (refill_en_i),
        .refill_lq_idx_i (refill_lq_idx_i),
        .refill_data_i   (refill_data_i),
        .wb_valid_o      (wb_valid_o),
        .wb_rd_o         (wb_rd_o),
        .wb_rob_idx_o    (wb_rob_idx_o),
        .wb_data_o       (wb_data_o),
        .wb_ready_i      (wb_ready_i),
        .commit_num_i    (commit_num_i)
    );

    bind load_queue load_queue_properties u_props (
        .clk          (clk),
        .rst          (rst),
        .dis_en_i     (dis_en_i),
        .full_i       (full_o),
        .wb_valid_i   (wb_valid_o),
        .wb_ready_i   (wb_ready_i),
        .wb_rd_i      (wb_rd_o),
        .wb_rob_idx_i (wb_rob_idx_o),
        .wb_data_i    (wb_data_o)
    );

    task automatic compare_value(string name, logic [63:0] exp_val, logic [63:0] act_val);
        checks++;
        assert (exp_val === act_val) else begin
            errors++;
            $display("Mismatch %s: expected %h, actual %h", name, exp_val, act_val);
        end
    endtask

    task automatic expect_true(logic cond, string msg);
        checks++;
        assert (cond) else begin
            errors++;
            $display("Error in %s: %s", cur_name, msg);
        end
    endtask

    function automatic int lowest_pending();
        for (int i = 0; i < LQ_DEPTH; i++) begin
            if (m_pend[i]) begin
                return i;
            end
        end
        return -1;
    endfunction

    // forwarded bytes are kept, the rest come from the refill line
    function automatic xdata_t merge_bytes(byte_mask_t mask, xdata_t fwd, xdata_t refill);
        xdata_t keep;
        for (int b = 0; b < DATA_BYTES; b++) begin
            keep[b*8 +: 8] = {8{mask[b]}};
        end
        return (fwd & keep) | (refill & ~keep);
    endfunction

    task automatic update_ready();
        case (ready_mode)
            0: wb_ready_i = 1'b0;
            1: wb_ready_i = 1'b1;
            default: begin
                if (stretch == 0) begin
                    ready_level = ~ready_level;
                    stretch = $urandom_range(1, 6);
                end
                stretch--;
                wb_ready_i = ready_level;
            end
        endcase
    endtask

    // every input changes 1 ns after the edge
    task automatic step();
        @(posedge clk);
        #1;
        update_ready();
    endtask

    task automatic do_dispatch(int cnt);
        for (int i = 0; i < cnt; i++) begin
            compare_value({cur_name, " lq_idx"}, tail_ptr % LQ_DEPTH, dis_lq_idx_o);
            compare_value({cur_name, " lq_dir"}, (tail_ptr / LQ_DEPTH) % 2, dis_lq_dir_o);
            expect_true(!full_o, "queue reports full before all loads were dispatched");
            if (!full_o) begin
                dis_rob_idx_i = rob_idx_t'($urandom);
                m_rob[tail_ptr % LQ_DEPTH] = dis_rob_idx_i;
                dis_en_i = 1'b1;
                step();
                dis_en_i = 1'b0;
                tail_ptr = (tail_ptr + 1) % (2 * LQ_DEPTH);
            end
        end
    endtask

    task automatic do_commit(int cnt);
        commit_num_i = CNT_W'(cnt);
        step();
        commit_num_i = '0;
    endtask

    task automatic do_issue(int slot, logic miss, byte_mask_t mask);
        iss_en_i = 1'b1;
        iss_lq_idx_i = IDX_W'(slot);
        iss_rd_i = reg_idx_t'($urandom);
        iss_we_i = 1'b1;
        iss_miss_i = miss;
        iss_fwd_mask_i = mask;
        iss_fwd_data_i = {$urandom, $urandom};
        m_rd[slot] = iss_rd_i;
        m_mask[slot] = mask;
        m_fwd[slot] = iss_fwd_data_i;
        step();
        iss_en_i = 1'b0;
    endtask

    task automatic do_refill(int slot);
        refill_en_i = 1'b1;
        refill_lq_idx_i = IDX_W'(slot);
        refill_data_i = {$urandom, $urandom};
        m_data[slot] = merge_bytes(m_mask[slot], m_fwd[slot], refill_data_i);
        step();
        refill_en_i = 1'b0;
        m_pend[slot] = 1'b1;
        // a free output register takes the lowest pending slot
        if (held_slot < 0) begin
            held_slot = lowest_pending();
        end
    endtask

    // checks each accepted writeback against the model
    always @(posedge clk) begin
        if (rst && wb_valid_o && wb_ready_i) begin
            if (held_slot < 0) begin
                expect_true(1'b0, "writeback transfer with no refilled load waiting");
            end else begin
                compare_value($sformatf("%s wb_rd slot %0d", cur_name, held_slot),
                              m_rd[held_slot], wb_rd_o);
                compare_value($sformatf("%s wb_rob_idx slot %0d", cur_name, held_slot),
                              m_rob[held_slot], wb_rob_idx_o);
                compare_value($sformatf("%s wb_data slot %0d", cur_name, held_slot),
                              m_data[held_slot], wb_data_o);
                m_pend[held_slot] = 1'b0;
                held_slot = lowest_pending();
            end
        end
    end

    initial begin : watchdog
        #(NROWS * 20 * CLK_PERIOD);
        $display("Timeout: run did not finish within %0d cycles", NROWS * 20);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        int prop_fails;
        void'($urandom(90));
        dis_en_i = 1'b0;
        dis_rob_idx_i = '0;
        iss_en_i = 1'b0;
        iss_lq_idx_i = '0;
        iss_rd_i = '0;
        iss_we_i = 1'b0;
        iss_miss_i = 1'b0;
        iss_fwd_mask_i = '0;
        iss_fwd_data_i = '0;
        refill_en_i = 1'b0;
        refill_lq_idx_i = '0;
        refill_data_i = '0;
        wb_ready_i = 1'b1;
        commit_num_i = '0;
        m_pend = '0;
        held_slot = -1;
        tail_ptr = 0;
        ready_mode = 1;
        stretch = 0;
        ready_level = 1'b1;
        errors = 0;
        checks = 0;
        cur_name = "reset";

        @(posedge rst);
        step();
        for (int r = 0; r < NROWS; r++) begin
            cur_name = rows[r].name;
            case (rows[r].op)
                OP_DISP: begin
                    do_dispatch(rows[r].cnt);
                    compare_value({cur_name, " full"}, rows[r].exp_full, full_o);
                end
                OP_COMMIT: begin
                    do_commit(rows[r].cnt);
                    compare_value({cur_name, " full"}, rows[r].exp_full, full_o);
                end
                OP_HIT: do_issue(rows[r].slot, 1'b0, rows[r].mask);
                OP_MISS: do_issue(rows[r].slot, 1'b1, rows[r].mask);
                OP_REFILL: do_refill(rows[r].slot);
                OP_READY: begin
                    ready_mode = rows[r].cnt;
                    step();
                end
                default: begin
                    while (held_slot >= 0) begin
                        step();
                    end
                    // room for a stray writeback to show up
                    repeat (3) step();
                end
            endcase
        end

        expect_true(held_slot < 0 && m_pend == '0, "refilled loads never written back");
        prop_fails = uut.u_props.fail_count;
        $display("checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, prop_fails);
        if (errors == 0 && prop_fails == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
hw/lq_pkg.sv
hw/lq_ram.sv
hw/lq_pointer_ctrl.sv
hw/lq_entry_state.sv
hw/lq_writeback.sv
hw/load_queue.sv
dv/lq_clk_gen.sv
dv/load_queue_properties.sv
dv/tb_load_queue.sv

//--- Bender.yml
package:
  name: load_queue

sources:
  - files:
      - hw/lq_pkg.sv
      - hw/lq_ram.sv
      - hw/lq_pointer_ctrl.sv
      - hw/lq_entry_state.sv
      - hw/lq_writeback.sv
      - hw/load_queue.sv
  - target: simulation
    files:
      - dv/lq_clk_gen.sv
      - dv/load_queue_properties.sv
      - dv/tb_load_queue.sv
